// File: src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // Datapath and register file sizes.
    localparam int data_width    = 32;
    localparam int num_regs      = 8;
    localparam int reg_idx_width = 3;
    localparam int addr_reg      = 7; // Register h holds the data address.

    // Instruction field positions.
    localparam int opcode_lsb = 0;
    localparam int opcode_msb = 3;
    localparam int rd_lsb     = 4;
    localparam int rd_msb     = 6;
    localparam int ra_lsb     = 7;
    localparam int ra_msb     = 9;
    localparam int rb_lsb     = 10;
    localparam int rb_msb     = 12;
    localparam int imm_lsb    = 13;
    localparam int imm_msb    = 28;
    localparam int imm_width  = 16;

    // Opcodes. Unlisted codes behave as a no-operation.
    localparam logic [3:0] op_add   = 4'h0;
    localparam logic [3:0] op_sub   = 4'h1;
    localparam logic [3:0] op_and   = 4'h2;
    localparam logic [3:0] op_or    = 4'h3;
    localparam logic [3:0] op_xor   = 4'h4;
    localparam logic [3:0] op_ldl   = 4'h5;
    localparam logic [3:0] op_ldh   = 4'h6;
    localparam logic [3:0] op_cmp   = 4'h7;
    localparam logic [3:0] op_load  = 4'h8;
    localparam logic [3:0] op_store = 4'h9;
    localparam logic [3:0] op_jmp   = 4'ha;
    localparam logic [3:0] op_brf   = 4'hb;
    localparam logic [3:0] op_halt  = 4'hc;

    typedef enum logic [2:0] {
        st_fetch,
        st_latch,
        st_exec,
        st_load,
        st_halt
    } seq_state;

endpackage

`default_nettype wire

// File: src/cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
    input  wire logic                               clock,
    input  wire logic                               rst,
    input  wire logic [cpu_pkg::reg_idx_width-1:0]  rd_idx_a,
    input  wire logic [cpu_pkg::reg_idx_width-1:0]  rd_idx_b,
    output logic      [cpu_pkg::data_width-1:0]     data_a,
    output logic      [cpu_pkg::data_width-1:0]     data_b,
    output logic                                    flag_a,
    output logic                                    flag_b,
    output logic      [cpu_pkg::data_width-1:0]     data_h,
    input  wire logic                               wr_en,
    input  wire logic [cpu_pkg::reg_idx_width-1:0]  wr_idx,
    input  wire logic [cpu_pkg::data_width-1:0]     wr_data,
    input  wire logic                               flag_wr_en,
    input  wire logic                               flag_wr
);

    logic [cpu_pkg::data_width-1:0] regs [cpu_pkg::num_regs];
    logic [cpu_pkg::num_regs-1:0]   flags;

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < cpu_pkg::num_regs; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                regs[wr_idx] <= wr_data;
            end
            if (flag_wr_en)
            begin
                flags[wr_idx] <= flag_wr; // Flag is written apart from the data.
            end
        end
    end

    // Read ports see the current contents, no bypass.
    assign data_a = regs[rd_idx_a];
    assign data_b = regs[rd_idx_b];
    assign flag_a = flags[rd_idx_a];
    assign flag_b = flags[rd_idx_b];
    assign data_h = regs[cpu_pkg::addr_reg];

endmodule

`default_nettype wire

// File: src/cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
    input  wire logic [cpu_pkg::data_width-1:0] instr,
    input  wire logic [cpu_pkg::data_width-1:0] data_a,
    input  wire logic [cpu_pkg::data_width-1:0] data_b,
    output logic      [cpu_pkg::data_width-1:0] result,
    output logic                                flag
);

    logic [3:0]                         opcode;
    logic [cpu_pkg::imm_width-1:0]      imm;
    logic [cpu_pkg::data_width:0]       sum;
    logic [cpu_pkg::data_width:0]       diff;

    assign opcode = instr[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb];
    assign imm    = instr[cpu_pkg::imm_msb:cpu_pkg::imm_lsb];

    // Extra top bit carries out of the add and borrows out of the subtract.
    assign sum  = {1'b0, data_a} + {1'b0, data_b};
    assign diff = {1'b0, data_a} - {1'b0, data_b};

    always_comb
    begin
        result = '0;
        flag   = 1'b0;
        case (opcode)
            cpu_pkg::op_add:
            begin
                result = sum[cpu_pkg::data_width-1:0];
                flag   = sum[cpu_pkg::data_width];
            end
            cpu_pkg::op_sub:
            begin
                result = diff[cpu_pkg::data_width-1:0];
                flag   = diff[cpu_pkg::data_width];
            end
            cpu_pkg::op_and:
            begin
                result = data_a & data_b;
                flag   = (result == '0);
            end
            cpu_pkg::op_or:
            begin
                result = data_a | data_b;
                flag   = (result == '0);
            end
            cpu_pkg::op_xor:
            begin
                result = data_a ^ data_b;
                flag   = (result == '0);
            end
            cpu_pkg::op_ldl: result = {{(cpu_pkg::data_width - cpu_pkg::imm_width){1'b0}}, imm};
            cpu_pkg::op_ldh: result = {imm, data_a[cpu_pkg::imm_width-1:0]}; // Low half kept.
            cpu_pkg::op_cmp: flag = (data_a == data_b);
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: src/cpu_next_addr.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_next_addr #(
    parameter int addr_width = 8
) (
    input  wire logic [addr_width-1:0]          pc,
    input  wire logic [cpu_pkg::data_width-1:0] instr,
    input  wire logic                           flag_a,
    output logic      [addr_width-1:0]          next_pc
);

    logic [3:0]            opcode;
    logic [addr_width-1:0] target;
    logic [addr_width-1:0] pc_inc;

    assign opcode = instr[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb];
    assign target = instr[cpu_pkg::imm_lsb +: addr_width]; // Low bits of imm.
    assign pc_inc = pc + addr_width'(1);                   // Wraps at addr_width.

    always_comb
    begin
        case (opcode)
            cpu_pkg::op_jmp: next_pc = target;
            cpu_pkg::op_brf: next_pc = flag_a ? target : pc_inc;
            default:         next_pc = pc_inc;
        endcase
    end

endmodule

`default_nettype wire

// File: src/cpu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer #(
    parameter int addr_width = 8
) (
    input  wire logic                               clock,
    input  wire logic                               rst,
    output logic      [addr_width-1:0]              mem_addr,
    output logic                                    mem_rd,
    output logic                                    mem_wr,
    output logic      [cpu_pkg::data_width-1:0]     mem_wdata,
    input  wire logic [cpu_pkg::data_width-1:0]     mem_rdata,
    output logic      [cpu_pkg::data_width-1:0]     instr,
    input  wire logic [cpu_pkg::data_width-1:0]     data_a,
    input  wire logic [cpu_pkg::data_width-1:0]     data_h,
    input  wire logic [cpu_pkg::data_width-1:0]     alu_result,
    input  wire logic                               alu_flag,
    input  wire logic [addr_width-1:0]              next_pc,
    output logic      [addr_width-1:0]              pc,
    output logic                                    wr_en,
    output logic      [cpu_pkg::reg_idx_width-1:0]  wr_idx,
    output logic      [cpu_pkg::data_width-1:0]     wr_data,
    output logic                                    flag_wr_en,
    output logic                                    flag_wr,
    output logic                                    halt
);

    cpu_pkg::seq_state state;
    logic              running;
    logic [3:0]        opcode;
    logic              in_exec;

    assign opcode  = instr[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb];
    assign in_exec = (state == cpu_pkg::st_exec);

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state   <= cpu_pkg::st_fetch;
            pc      <= '0;
            running <= 1'b0;
        end
        else
        begin
            running <= 1'b1; // Holds off the first fetch until reset is gone.
            case (state)
                cpu_pkg::st_fetch:
                begin
                    if (running)
                    begin
                        state <= cpu_pkg::st_latch;
                    end
                end
                cpu_pkg::st_latch: state <= cpu_pkg::st_exec;
                cpu_pkg::st_exec:
                begin
                    if (opcode == cpu_pkg::op_halt)
                    begin
                        state <= cpu_pkg::st_halt;
                    end
                    else
                    begin
                        pc <= next_pc;
                        if (opcode == cpu_pkg::op_load)
                        begin
                            state <= cpu_pkg::st_load;
                        end
                        else
                        begin
                            state <= cpu_pkg::st_fetch;
                        end
                    end
                end
                cpu_pkg::st_load: state <= cpu_pkg::st_fetch;
                default: state <= cpu_pkg::st_halt; // Only reset leaves halt.
            endcase
        end
    end

    // Instruction word arrives one cycle after the fetch strobe.
    always_ff @(posedge clock)
    begin
        if (state == cpu_pkg::st_latch)
        begin
            instr <= mem_rdata;
        end
    end

    // Memory strobes.
    assign mem_rd    = ((state == cpu_pkg::st_fetch) && running) ||
                       (in_exec && (opcode == cpu_pkg::op_load));
    assign mem_wr    = in_exec && (opcode == cpu_pkg::op_store);
    assign mem_addr  = (state == cpu_pkg::st_fetch) ? pc : data_h[addr_width-1:0];
    assign mem_wdata = data_a;
    assign halt      = (state == cpu_pkg::st_halt);

    // Write-back select.
    assign wr_idx = instr[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];

    always_comb
    begin
        wr_en      = 1'b0;
        flag_wr_en = 1'b0;
        wr_data    = alu_result;
        flag_wr    = alu_flag;
        case (state)
            cpu_pkg::st_exec:
            begin
                case (opcode)
                    cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_or,
                    cpu_pkg::op_xor, cpu_pkg::op_ldl, cpu_pkg::op_ldh:
                    begin
                        wr_en      = 1'b1;
                        flag_wr_en = 1'b1;
                    end
                    cpu_pkg::op_cmp: flag_wr_en = 1'b1; // Compare touches only the flag.
                    default: ;
                endcase
            end
            cpu_pkg::st_load:
            begin
                wr_en   = 1'b1;
                wr_data = mem_rdata;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: src/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter int addr_width = 8
) (
    input  wire logic                           clock,
    input  wire logic                           rst,
    output logic      [addr_width-1:0]          mem_addr,
    output logic                                mem_rd,
    output logic                                mem_wr,
    output logic      [cpu_pkg::data_width-1:0] mem_wdata,
    input  wire logic [cpu_pkg::data_width-1:0] mem_rdata,
    output logic                                halt
);

    logic [cpu_pkg::data_width-1:0]    instr;
    logic [cpu_pkg::data_width-1:0]    data_a;
    logic [cpu_pkg::data_width-1:0]    data_b;
    logic [cpu_pkg::data_width-1:0]    data_h;
    logic                              flag_a;
    logic [cpu_pkg::data_width-1:0]    alu_result;
    logic                              alu_flag;
    logic [addr_width-1:0]             pc;
    logic [addr_width-1:0]             next_pc;
    logic                              wr_en;
    logic [cpu_pkg::reg_idx_width-1:0] wr_idx;
    logic [cpu_pkg::data_width-1:0]    wr_data;
    logic                              flag_wr_en;
    logic                              flag_wr;

    cpu_sequencer #(
        .addr_width (addr_width)
    ) u_cpu_sequencer (
        .clock      (clock),
        .rst        (rst),
        .mem_addr   (mem_addr),
        .mem_rd     (mem_rd),
        .mem_wr     (mem_wr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .instr      (instr),
        .data_a     (data_a),
        .data_h     (data_h),
        .alu_result (alu_result),
        .alu_flag   (alu_flag),
        .next_pc    (next_pc),
        .pc         (pc),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .flag_wr_en (flag_wr_en),
        .flag_wr    (flag_wr),
        .halt       (halt)
    );

    // Read indices come straight from the latched ra and rb fields.
    cpu_regfile u_cpu_regfile (
        .clock      (clock),
        .rst        (rst),
        .rd_idx_a   (instr[cpu_pkg::ra_msb:cpu_pkg::ra_lsb]),
        .rd_idx_b   (instr[cpu_pkg::rb_msb:cpu_pkg::rb_lsb]),
        .data_a     (data_a),
        .data_b     (data_b),
        .flag_a     (flag_a),
        .flag_b     (),
        .data_h     (data_h),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .flag_wr_en (flag_wr_en),
        .flag_wr    (flag_wr)
    );

    cpu_alu u_cpu_alu (
        .instr  (instr),
        .data_a (data_a),
        .data_b (data_b),
        .result (alu_result),
        .flag   (alu_flag)
    );

    cpu_next_addr #(
        .addr_width (addr_width)
    ) u_cpu_next_addr (
        .pc      (pc),
        .instr   (instr),
        .flag_a  (flag_a),
        .next_pc (next_pc)
    );

endmodule

`default_nettype wire

// File: verif/cpu_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_chk (
    input wire logic clock,
    input wire logic rst,
    input wire logic mem_rd,
    input wire logic mem_wr,
    input wire logic halt
);

    // Single memory port.
    rd_wr_exclusive: assert property (@(posedge clock) disable iff (rst) !(mem_rd && mem_wr))
        else $error("mem_rd and mem_wr were high in the same cycle");

    reset_idle: assert property (@(posedge clock) rst |=> (!halt && !mem_rd && !mem_wr))
        else $error("halt or a memory strobe was active right after reset");

    // Only reset leaves the halt state.
    halt_sticky: assert property (@(posedge clock) disable iff (rst) halt |=> halt)
        else $error("halt dropped without a reset");

    halt_quiet: assert property (@(posedge clock) disable iff (rst) halt |-> (!mem_rd && !mem_wr))
        else $error("memory strobe issued while halted");

    wr_single: assert property (@(posedge clock) disable iff (rst) mem_wr |=> !mem_wr)
        else $error("mem_wr lasted more than one cycle");

endmodule

bind cpu_top cpu_chk u_cpu_chk (
    .clock  (clock),
    .rst    (rst),
    .mem_rd (mem_rd),
    .mem_wr (mem_wr),
    .halt   (halt)
);

`default_nettype wire

// File: verif/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    localparam int addr_width = 8;
    localparam int mem_words  = 1 << addr_width;

    logic                  clock;
    logic                  rst;
    logic [addr_width-1:0] mem_addr;
    logic                  mem_rd;
    logic                  mem_wr;
    logic [31:0]           mem_wdata;
    logic [31:0]           mem_rdata;
    logic                  halt;

    logic [31:0] mem [mem_words];
    logic [7:0]  prog_pc;
    logic [7:0]  data_ptr;
    logic [7:0]  exp_addr [$];
    logic [31:0] exp_data [$];
    int          store_count;
    int          ref_steps;
    int          timeout_cycles;
    logic        ref_ready;
    logic        rd_pending;
    logic [31:0] rd_word;
    integer      seed;

    cpu_top #(
        .addr_width (addr_width)
    ) u_cpu_top (
        .clock     (clock),
        .rst       (rst),
        .mem_addr  (mem_addr),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .halt      (halt)
    );

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("ERR %0t ns: %s", $time, msg);
        abort_run();
    endtask

    function automatic logic [31:0] encode_instr(input logic [3:0] op, input logic [2:0] rd,
                                                 input logic [2:0] ra, input logic [2:0] rb,
                                                 input logic [15:0] imm);
        return {3'b000, imm, rb, ra, rd, op};
    endfunction

    task automatic emit_word(input logic [31:0] word);
        mem[prog_pc] = word;
        prog_pc      = prog_pc + 8'd1;
    endtask

    // Full 32-bit constant as ldl then ldh on the same register.
    task automatic emit_const(input logic [2:0] rd, input logic [31:0] value);
        emit_word(encode_instr(cpu_pkg::op_ldl, rd, 3'd0, 3'd0, value[15:0]));
        emit_word(encode_instr(cpu_pkg::op_ldh, rd, rd, 3'd0, value[31:16]));
    endtask

    task automatic emit_set_addr(input logic [7:0] addr);
        emit_word(encode_instr(cpu_pkg::op_ldl, 3'd7, 3'd0, 3'd0, {8'h00, addr}));
    endtask

    task automatic emit_store(input logic [2:0] ra);
        emit_word(encode_instr(cpu_pkg::op_store, 3'd0, ra, 3'd0, 16'h0000));
    endtask

    // Fresh address and a brf over one store. The flag decides which stores land.
    task automatic emit_flag_probe(input logic [2:0] flag_reg, input logic [2:0] skipped,
                                   input logic [2:0] kept);
        emit_set_addr(data_ptr);
        data_ptr = data_ptr + 8'd1;
        emit_word(encode_instr(cpu_pkg::op_brf, 3'd0, flag_reg, 3'd0, {8'h00, prog_pc + 8'd2}));
        emit_store(skipped);
        emit_store(kept);
    endtask

    task automatic build_program();
        logic [19:0] alu_ops;
        logic [3:0]  op;
        logic [2:0]  rb;
        logic [31:0] a;
        logic [31:0] b;
        alu_ops  = {cpu_pkg::op_xor, cpu_pkg::op_or, cpu_pkg::op_and, cpu_pkg::op_sub,
                    cpu_pkg::op_add};
        prog_pc  = 8'h00;
        data_ptr = 8'hc0; // Data area sits above the program.
        for (int k = 0; k < 5; k++)
        begin
            op = alu_ops[4*k +: 4];
            for (int round = 0; round < 2; round++)
            begin
                a  = $random(seed);
                b  = $random(seed);
                rb = (round == 0) ? 3'd2 : 3'd1; // Second round uses ra for both operands.
                if (op == cpu_pkg::op_add)
                begin
                    a[31] = (round == 0);
                    b[31] = 1'b1;        // Carry in round 0 and none for a+a in round 1.
                end
                if (op == cpu_pkg::op_sub && round == 0)
                begin
                    a[31] = 1'b0;
                    b[31] = 1'b1;        // Forces a borrow.
                end
                emit_const(3'd1, a);
                if (round == 0)
                begin
                    emit_const(3'd2, b);
                end
                emit_word(encode_instr(op, 3'd3, 3'd1, rb, 16'h0000));
                emit_flag_probe(3'd3, 3'd1, 3'd3);
            end
        end
        // Immediates.
        for (int k = 0; k < 3; k++)
        begin
            emit_const(3'(k), $random(seed));
            emit_set_addr(data_ptr);
            data_ptr = data_ptr + 8'd1;
            emit_store(3'(k));
        end
        // Store, load back into r5 and store again.
        emit_const(3'd4, $random(seed));
        emit_set_addr(data_ptr);
        emit_store(3'd4);
        emit_word(encode_instr(cpu_pkg::op_load, 3'd5, 3'd0, 3'd0, 16'h0000));
        emit_set_addr(data_ptr + 8'd1);
        emit_store(3'd5);
        emit_set_addr(8'hfe); // Never written so it holds the fill pattern.
        emit_word(encode_instr(cpu_pkg::op_load, 3'd5, 3'd0, 3'd0, 16'h0000));
        emit_set_addr(data_ptr + 8'd2);
        emit_store(3'd5);
        data_ptr = data_ptr + 8'd3;
        // Control flow.
        emit_set_addr(data_ptr);
        data_ptr = data_ptr + 8'd1;
        emit_word(encode_instr(cpu_pkg::op_jmp, 3'd0, 3'd0, 3'd0, {8'h00, prog_pc + 8'd2}));
        emit_store(3'd1);
        emit_store(3'd4);
        emit_word(encode_instr(4'hd, 3'd0, 3'd0, 3'd0, 16'h0000)); // Unused code acts as a no-op.
        a = $random(seed);
        emit_const(3'd1, a);
        emit_word(encode_instr(cpu_pkg::op_or, 3'd2, 3'd1, 3'd1, 16'h0000));
        emit_word(encode_instr(cpu_pkg::op_cmp, 3'd6, 3'd1, 3'd2, 16'h0000));
        emit_flag_probe(3'd6, 3'd1, 3'd2);                         // Equal so the branch is taken.
        emit_const(3'd2, a ^ 32'h0000_0001);
        emit_word(encode_instr(cpu_pkg::op_cmp, 3'd6, 3'd1, 3'd2, 16'h0000));
        emit_flag_probe(3'd6, 3'd1, 3'd2);                         // Not equal so it falls through.
        emit_word(encode_instr(cpu_pkg::op_halt, 3'd0, 3'd0, 3'd0, 16'h0000));
        if (prog_pc >= 8'hc0)
        begin
            $display("The generated program runs into the data area.");
            abort_run();
        end
    endtask

    // Instruction-set model of the CPU that collects the expected stores.
    task automatic run_reference();
        logic [31:0] rm_mem [mem_words];
        logic [31:0] regs [8];
        logic [7:0]  flags;
        logic [7:0]  pc;
        logic [7:0]  next_pc;
        logic [31:0] iw;
        logic [31:0] va;
        logic [31:0] vb;
        logic        done;
        for (int i = 0; i < mem_words; i++)
        begin
            rm_mem[i] = mem[i];
        end
        for (int i = 0; i < 8; i++)
        begin
            regs[i] = '0;
        end
        flags     = '0;
        pc        = '0;
        done      = 1'b0;
        ref_steps = 0;
        while (!done && ref_steps < 1000)
        begin
            iw        = rm_mem[pc];
            va        = regs[iw[9:7]];
            vb        = regs[iw[12:10]];
            next_pc   = pc + 8'd1;
            ref_steps = ref_steps + 1;
            case (iw[3:0])
                cpu_pkg::op_add:
                begin
                    regs[iw[6:4]]  = va + vb;
                    flags[iw[6:4]] = ((va + vb) < va); // A carry leaves the sum below an operand.
                end
                cpu_pkg::op_sub:
                begin
                    regs[iw[6:4]]  = va - vb;
                    flags[iw[6:4]] = (va < vb);
                end
                cpu_pkg::op_and, cpu_pkg::op_or, cpu_pkg::op_xor:
                begin
                    if (iw[3:0] == cpu_pkg::op_and) regs[iw[6:4]] = va & vb;
                    else if (iw[3:0] == cpu_pkg::op_or) regs[iw[6:4]] = va | vb;
                    else regs[iw[6:4]] = va ^ vb;
                    flags[iw[6:4]] = (regs[iw[6:4]] == 32'h0);
                end
                cpu_pkg::op_ldl:
                begin
                    regs[iw[6:4]]  = {16'h0000, iw[28:13]};
                    flags[iw[6:4]] = 1'b0;
                end
                cpu_pkg::op_ldh:
                begin
                    regs[iw[6:4]]  = {iw[28:13], va[15:0]};
                    flags[iw[6:4]] = 1'b0;
                end
                cpu_pkg::op_cmp:   flags[iw[6:4]] = (va == vb);
                cpu_pkg::op_load:  regs[iw[6:4]] = rm_mem[regs[7][7:0]];
                cpu_pkg::op_store:
                begin
                    rm_mem[regs[7][7:0]] = va;
                    exp_addr.push_back(regs[7][7:0]);
                    exp_data.push_back(va);
                end
                cpu_pkg::op_jmp:   next_pc = iw[20:13];
                cpu_pkg::op_brf:   next_pc = flags[iw[9:7]] ? iw[20:13] : next_pc;
                cpu_pkg::op_halt:  done = 1'b1;
                default: ;
            endcase
            pc = next_pc;
        end
        if (!done)
        begin
            $display("The reference model did not reach HALT.");
            abort_run();
        end
    endtask

    // Memory model answers a read in the following cycle.
    always @(negedge clock)
    begin
        if (rd_pending)
        begin
            mem_rdata = rd_word;
        end
        rd_pending = mem_rd;
        if (mem_rd)
        begin
            rd_word = mem[mem_addr];
        end
        if (halt)
        begin
            assert (!mem_rd && !mem_wr) else report_error("memory strobe while halted");
        end
        if (mem_wr)
        begin
            assert (store_count < exp_addr.size())
                else report_error($sformatf("unexpected store %h at %h", mem_wdata, mem_addr));
            assert (mem_addr == exp_addr[store_count] && mem_wdata == exp_data[store_count])
                else report_error($sformatf("store %0d: got %h at %h, expected %h at %h",
                                            store_count, mem_wdata, mem_addr,
                                            exp_data[store_count], exp_addr[store_count]));
            mem[mem_addr] = mem_wdata;
            store_count   = store_count + 1;
        end
    end

    initial
    begin
        wait (ref_ready);
        repeat (timeout_cycles) @(posedge clock);
        $display("Timeout: the CPU did not halt within %0d cycles.", timeout_cycles);
        abort_run();
    end

    initial
    begin
        rst         = 1'b1;
        mem_rdata   = '0;
        ref_ready   = 1'b0;
        rd_pending  = 1'b0;
        rd_word     = '0;
        store_count = 0;
        seed        = 32'hee39b5bc;
        for (int i = 0; i < mem_words; i++)
        begin
            mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'hc3a5_5a3c;
        end
        build_program();
        run_reference();
        timeout_cycles = 8 + 4 * ref_steps + 50;
        ref_ready      = 1'b1;
        repeat (8) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        while (!halt) @(negedge clock);
        repeat (10) @(negedge clock); // Quiet window after halt.
        if (store_count == exp_addr.size())
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
        else
        begin
            report_error($sformatf("%0d stores seen, %0d expected", store_count, exp_addr.size()));
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
src/cpu_pkg.sv
src/cpu_regfile.sv
src/cpu_alu.sv
src/cpu_next_addr.sv
src/cpu_sequencer.sv
src/cpu_top.sv
verif/cpu_chk.sv
verif/cpu_tb.sv

// File: Makefile
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= cpu_tb
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
